// File: hdl/coreMemTypesPkg.sv
package coreMemTypesPkg;

    // Core data path widths
    localparam int WORD_W    = 32;
    localparam int BYTE_EN_W = WORD_W / 8;

    // Board IO widths
    localparam int SWITCH_W = 10;
    localparam int LED_W    = 10;
    localparam int SEG_W    = 24;

    typedef logic [WORD_W-1:0]    tWord;
    typedef logic [WORD_W-1:0]    tAddr;
    typedef logic [BYTE_EN_W-1:0] tByteEn;

    // Switch bank and LED bank on the board
    typedef logic [SWITCH_W-1:0]  tSwitch;
    typedef logic [LED_W-1:0]     tLed;
    // Six digits, four bits each
    typedef logic [SEG_W-1:0]     tSeg;

endpackage

// File: hdl/coreMemMapPkg.sv
package coreMemMapPkg;

    // ------------------------------------------------------------------------
    // Region decode on address bits 31:12
    // ------------------------------------------------------------------------
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 12;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    // Data window at 0x0001_0000, one 4 KB page
    localparam logic [REGION_W-1:0] D_MEM_REGION_FLOOR  = 20'h00010;
    localparam logic [REGION_W-1:0] D_MEM_REGION_ROOF   = 20'h00010;
    // Control window at 0x0002_0000
    localparam logic [REGION_W-1:0] CR_MEM_REGION_FLOOR = 20'h00020;
    localparam logic [REGION_W-1:0] CR_MEM_REGION_ROOF  = 20'h00020;

    // Decoded target of one data access
    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_DMEM,
        REGION_CRMEM
    } tRegion;

    // ------------------------------------------------------------------------
    // Memory sizes in words
    // ------------------------------------------------------------------------
    localparam int I_MEM_AW    = 10;
    localparam int I_MEM_DEPTH = 1 << I_MEM_AW;
    localparam int D_MEM_AW    = 10;
    localparam int D_MEM_DEPTH = 1 << D_MEM_AW;

    // Instruction image loaded at time zero
    localparam string I_MEM_INIT_FILE = "test/instrMem.hex";

    // Control register word offsets, address bits 7:2
    localparam logic [5:0] CR_LED     = 6'd0;
    localparam logic [5:0] CR_SEG     = 6'd1;
    localparam logic [5:0] CR_BUTTON  = 6'd2;
    localparam logic [5:0] CR_SWITCH  = 6'd3;
    localparam logic [5:0] CR_SCRATCH = 6'd4;

endpackage

// File: hdl/memPortIf.sv
`timescale 1ns/100ps

interface memPortIf
    import coreMemTypesPkg::*;
();

    // Request from the wrapper, already region gated
    tAddr   addr;
    tWord   wrData;
    tByteEn byteEn;
    logic   wrEn;
    logic   rdEn;
    // Registered response from the target
    tWord   rdData;

    modport initiator (
        output addr,
        output wrData,
        output byteEn,
        output wrEn,
        output rdEn,
        input  rdData
    );

    modport target (
        input  addr,
        input  wrData,
        input  byteEn,
        input  wrEn,
        input  rdEn,
        output rdData
    );

endinterface

// File: hdl/instrMem.sv
`timescale 1ns/100ps

module instrMem
    import coreMemTypesPkg::*;
    import coreMemMapPkg::*;
(
    input  logic Clk,
    input  tAddr pcQ100H,
    output tWord instructionQ101H
);

    tWord                mem [I_MEM_DEPTH];
    logic [I_MEM_AW-1:0] wordIndex;

    // Program image
    initial begin
        $readmemh(I_MEM_INIT_FILE, mem);
    end

    // Byte PC to word index
    assign wordIndex = pcQ100H[I_MEM_AW+1:2];

    // One cycle fetch latency
    always_ff @(posedge Clk) begin
        instructionQ101H <= mem[wordIndex];
    end

endmodule

// File: hdl/dataMem.sv
`timescale 1ns/100ps

module dataMem
    import coreMemTypesPkg::*;
    import coreMemMapPkg::*;
(
    input  logic            Clk,
    memPortIf.target        port
);

    tWord                mem [D_MEM_DEPTH];
    logic [D_MEM_AW-1:0] wordIndex;
    logic [1:0]          byteOffset;

    tWord   shiftWrData;
    tByteEn shiftByteEn;

    // Read stage state
    tWord       rdWord;
    logic [1:0] rdOffset;

    assign wordIndex  = port.addr[D_MEM_AW+1:2];
    assign byteOffset = port.addr[1:0];

    // ------------------------------------------------------------------------
    // Write alignment
    // ------------------------------------------------------------------------
    // Data and enables move up by the byte offset
    // Bytes pushed past bit 31 are lost, no spill into the next word
    always_comb begin
        shiftWrData = port.wrData << {byteOffset, 3'b000};
        shiftByteEn = port.byteEn << byteOffset;
    end

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (port.wrEn) begin
            for (int b = 0; b < BYTE_EN_W; b++) begin
                // Only enabled lanes of the addressed word
                if (shiftByteEn[b]) begin
                    mem[wordIndex][8*b +: 8] <= shiftWrData[8*b +: 8];
                end
            end
        end
        // Old contents on a same cycle read and write
        if (port.rdEn) begin
            rdWord   <= mem[wordIndex];
            rdOffset <= byteOffset;
        end
    end

    // ------------------------------------------------------------------------
    // Read alignment
    // ------------------------------------------------------------------------
    // Addressed byte lands in bits 7:0
    // Upper bytes zero filled, sign extension is left to the core
    assign port.rdData = rdWord >> {rdOffset, 3'b000};

endmodule

// File: hdl/ctrlRegFile.sv
`timescale 1ns/100ps

module ctrlRegFile
    import coreMemTypesPkg::*;
    import coreMemMapPkg::*;
(
    input  logic            Clk,
    input  logic            rstN,
    memPortIf.target        port,
    input  logic            button0,
    input  logic            button1,
    input  tSwitch          switch,
    output tLed             ledOut,
    output tSeg             segOut
);

    // Writeable registers
    tLed  ledQ;
    tSeg  segQ;
    tWord scratchQ;

    // Two flop synchronizers, bit 1 is button1
    logic [1:0] buttonMeta;
    logic [1:0] buttonSync;
    tSwitch     switchMeta;
    tSwitch     switchSync;

    logic [5:0] offset;
    tWord       rdMux;

    // Word offset inside the control window
    assign offset = port.addr[7:2];

    // ------------------------------------------------------------------------
    // Board input synchronizers
    // ------------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            buttonMeta <= '0;
            buttonSync <= '0;
            switchMeta <= '0;
            switchSync <= '0;
        end else begin
            buttonMeta <= {button1, button0};
            buttonSync <= buttonMeta;
            switchMeta <= switch;
            switchSync <= switchMeta;
        end
    end

    // ------------------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------------------
    // Full word writes, each register truncates to its width
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            ledQ     <= '0;
            segQ     <= '0;
            scratchQ <= '0;
        end else if (port.wrEn) begin
            case (offset)
                CR_LED:     ledQ     <= tLed'(port.wrData);
                CR_SEG:     segQ     <= tSeg'(port.wrData);
                CR_SCRATCH: scratchQ <= port.wrData;
                // Button and switch offsets are read only
                default:    ;
            endcase
        end
    end

    // Read select, zero extended
    always_comb begin
        case (offset)
            CR_LED:     rdMux = tWord'(ledQ);
            CR_SEG:     rdMux = tWord'(segQ);
            CR_BUTTON:  rdMux = tWord'(buttonSync);
            CR_SWITCH:  rdMux = tWord'(switchSync);
            CR_SCRATCH: rdMux = scratchQ;
            default:    rdMux = '0;
        endcase
    end

    // Registered response, held between strobes
    always_ff @(posedge Clk) begin
        if (port.rdEn) begin
            port.rdData <= rdMux;
        end
    end

    // Outputs follow the registers right after the write edge
    assign ledOut = ledQ;
    assign segOut = segQ;

endmodule

// File: hdl/coreMemWrap.sv
`timescale 1ns/100ps

module coreMemWrap
    import coreMemTypesPkg::*;
    import coreMemMapPkg::*;
(
    input  logic   Clk,
    input  logic   rstN,
    // Fetch
    input  tAddr   pcQ100H,
    output tWord   instructionQ101H,
    // Load and store from the core
    input  tWord   dMemWrDataQ103H,
    input  tAddr   dMemAddressQ103H,
    input  tByteEn dMemByteEnQ103H,
    input  logic   dMemWrEnQ103H,
    input  logic   dMemRdEnQ103H,
    output tWord   dMemRdRspQ104H,
    // Board IO
    input  logic   button0,
    input  logic   button1,
    input  tSwitch switch,
    output tLed    ledOut,
    output tSeg    segOut
);

    logic [REGION_W-1:0] regionField;
    tRegion              regionQ103H;
    tRegion              regionQ104H;

    memPortIf dPort ();
    memPortIf crPort ();

    // ------------------------------------------------------------------------
    // Region decode, once per access
    // ------------------------------------------------------------------------
    assign regionField = dMemAddressQ103H[REGION_MSB:REGION_LSB];

    always_comb begin
        if (regionField >= D_MEM_REGION_FLOOR && regionField <= D_MEM_REGION_ROOF) begin
            regionQ103H = REGION_DMEM;
        end else if (regionField >= CR_MEM_REGION_FLOOR &&
                     regionField <= CR_MEM_REGION_ROOF) begin
            regionQ103H = REGION_CRMEM;
        end else begin
            regionQ103H = REGION_NONE;
        end
    end

    // Region follows the access into Q104 to steer the response
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            regionQ104H <= REGION_NONE;
        end else begin
            regionQ104H <= regionQ103H;
        end
    end

    // Shared request fields, only the strobes are region gated
    assign dPort.addr    = dMemAddressQ103H;
    assign dPort.wrData  = dMemWrDataQ103H;
    assign dPort.byteEn  = dMemByteEnQ103H;
    assign dPort.wrEn    = dMemWrEnQ103H && (regionQ103H == REGION_DMEM);
    assign dPort.rdEn    = dMemRdEnQ103H && (regionQ103H == REGION_DMEM);

    assign crPort.addr   = dMemAddressQ103H;
    assign crPort.wrData = dMemWrDataQ103H;
    assign crPort.byteEn = dMemByteEnQ103H;
    assign crPort.wrEn   = dMemWrEnQ103H && (regionQ103H == REGION_CRMEM);
    assign crPort.rdEn   = dMemRdEnQ103H && (regionQ103H == REGION_CRMEM);

    // Response mux, unmapped reads give zero
    always_comb begin
        case (regionQ104H)
            REGION_DMEM:  dMemRdRspQ104H = dPort.rdData;
            REGION_CRMEM: dMemRdRspQ104H = crPort.rdData;
            default:      dMemRdRspQ104H = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Memories
    // ------------------------------------------------------------------------
    instrMem uInstrMem (
        .Clk              (Clk),
        .pcQ100H          (pcQ100H),
        .instructionQ101H (instructionQ101H)
    );

    dataMem uDataMem (
        .Clk  (Clk),
        .port (dPort.target)
    );

    ctrlRegFile uCtrlRegFile (
        .Clk     (Clk),
        .rstN    (rstN),
        .port    (crPort.target),
        .button0 (button0),
        .button1 (button1),
        .switch  (switch),
        .ledOut  (ledOut),
        .segOut  (segOut)
    );

endmodule

// File: test/coreMemWrap_sva.sv
`timescale 1ns/100ps

module coreMemWrapSva
    import coreMemTypesPkg::*;
    import coreMemMapPkg::*;
(
    input logic   Clk,
    input logic   rstN,
    input tAddr   dMemAddressQ103H,
    input logic   dWrEn,
    input logic   dRdEn,
    input logic   crWrEn,
    input logic   crRdEn,
    input logic   dMemRdEnQ103H,
    input tWord   dMemRdRspQ104H,
    input tLed    ledOut,
    input tSeg    segOut
);

    logic [REGION_W-1:0] tagField;
    logic                inData;
    logic                inCtrl;

    // Windows taken straight from the core address
    assign tagField = dMemAddressQ103H[REGION_MSB:REGION_LSB];
    assign inData   = tagField >= D_MEM_REGION_FLOOR && tagField <= D_MEM_REGION_ROOF;
    assign inCtrl   = tagField >= CR_MEM_REGION_FLOOR && tagField <= CR_MEM_REGION_ROOF;

    // One region port strobe per cycle
    oneStrobe: assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0({dWrEn, dRdEn, crWrEn, crRdEn}))
        else $error("more than one region strobe active");

    // Port writes only inside their own window
    noWriteUnmapped: assert property (@(posedge Clk) disable iff (!rstN)
        (!dWrEn || inData) && (!crWrEn || inCtrl))
        else $error("write reached a port for an unmapped address");

    // Board outputs cleared by reset
    outputsAfterReset: assert property (@(posedge Clk)
        $rose(rstN) |-> (ledOut == '0 && segOut == '0))
        else $error("board outputs not zero after reset");

    unmappedReadZero: assert property (@(posedge Clk) disable iff (!rstN)
        (dMemRdEnQ103H && !inData && !inCtrl) |=> (dMemRdRspQ104H == '0))
        else $error("unmapped read returned a nonzero response");

endmodule

bind coreMemWrap coreMemWrapSva uSva (
    .Clk              (Clk),
    .rstN             (rstN),
    .dMemAddressQ103H (dMemAddressQ103H),
    .dWrEn            (dPort.wrEn),
    .dRdEn            (dPort.rdEn),
    .crWrEn           (crPort.wrEn),
    .crRdEn           (crPort.rdEn),
    .dMemRdEnQ103H    (dMemRdEnQ103H),
    .dMemRdRspQ104H   (dMemRdRspQ104H),
    .ledOut           (ledOut),
    .segOut           (segOut)
);

// File: test/coreMemWrapTb.sv
`timescale 1ns/100ps

module coreMemWrapTb
    import coreMemTypesPkg::*;
();

    // Address map as seen by the core
    localparam tAddr        DMEM_BASE  = 32'h0001_0000;
    localparam tAddr        CR_BASE    = 32'h0002_0000;
    localparam logic [19:0] DMEM_TAG   = 20'h00010;
    localparam logic [19:0] CR_TAG     = 20'h00020;
    localparam int          WAIT_LIMIT = 64;

    logic   Clk;
    logic   rstN;
    tAddr   pcQ100H;
    tWord   instructionQ101H;
    tWord   dMemWrDataQ103H;
    tAddr   dMemAddressQ103H;
    tByteEn dMemByteEnQ103H;
    logic   dMemWrEnQ103H;
    logic   dMemRdEnQ103H;
    tWord   dMemRdRspQ104H;
    logic   button0;
    logic   button1;
    tSwitch switch;
    tLed    ledOut;
    tSeg    segOut;

    // Reference state
    logic [7:0] dShadow [4096];
    tWord       imgShadow [16];
    tLed        ledS;
    tSeg        segS;
    tWord       scratchS;
    logic [31:0] rngState;

    // Reads in flight
    tWord  expQ [$];
    string nameQ [$];
    string testName;
    string nameNow;
    tWord  expWord;
    logic  strobeSeen;
    int    checkCount;

    coreMemWrap u_dut (.*);

    always #5 Clk = ~Clk;

    // xorshift32
    function automatic tWord nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic void updateShadow(input tAddr a, input tWord d, input tByteEn be);
        int lane;
        if (a[31:12] == DMEM_TAG) begin
            for (int b = 0; b < 4; b++) begin
                // Lanes shifted past byte 3 are dropped
                lane = b + a[1:0];
                if (be[b] && lane < 4) begin
                    dShadow[{a[11:2], 2'b00} + lane] = d[8*b +: 8];
                end
            end
        end else if (a[31:12] == CR_TAG) begin
            case (a[7:2])
                6'd0:    ledS = d[9:0];
                6'd1:    segS = d[23:0];
                6'd4:    scratchS = d;
                default: ;
            endcase
        end
    endfunction

    function automatic tWord expectedRead(input tAddr a);
        tWord word;
        word = '0;
        if (a[31:12] == DMEM_TAG) begin
            for (int b = 0; b < 4; b++) begin
                word[8*b +: 8] = dShadow[{a[11:2], 2'b00} + b];
            end
            // Addressed byte down to bit 0, zero fill above
            word = word >> (8 * a[1:0]);
        end else if (a[31:12] == CR_TAG) begin
            case (a[7:2])
                6'd0:    word = 32'(ledS);
                6'd1:    word = 32'(segS);
                6'd2:    word = {30'd0, button1, button0};
                6'd3:    word = 32'(switch);
                6'd4:    word = scratchS;
                default: word = '0;
            endcase
        end
        return word;
    endfunction

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic waitCycles(input int n);
        int count;
        count = 0;
        while (count < n) begin
            if (count >= WAIT_LIMIT) begin
                reportFailure("timed out waiting for clock cycles");
            end
            @(posedge Clk);
            count++;
        end
    endtask

    // One bus strobe, write or read
    task automatic access(input logic wr, input tAddr a, input tWord d, input tByteEn be);
        @(posedge Clk);
        dMemAddressQ103H <= a;
        dMemWrDataQ103H  <= d;
        dMemByteEnQ103H  <= be;
        dMemWrEnQ103H    <= wr;
        dMemRdEnQ103H    <= !wr;
        if (wr) begin
            updateShadow(a, d, be);
        end else begin
            expQ.push_back(expectedRead(a));
            nameQ.push_back(testName);
        end
    endtask

    task automatic idleBus();
        @(posedge Clk);
        dMemWrEnQ103H <= 1'b0;
        dMemRdEnQ103H <= 1'b0;
    endtask

    task automatic checkOutputs();
        @(negedge Clk);
        assert (ledOut === ledS) else begin
            reportFailure($sformatf("error %s ledOut expected %h actual %h",
                                    testName, ledS, ledOut));
        end
        assert (segOut === segS) else begin
            reportFailure($sformatf("error %s segOut expected %h actual %h",
                                    testName, segS, segOut));
        end
    endtask

    task automatic drainChecks();
        int guard;
        guard = 0;
        while (expQ.size() > 0) begin
            if (guard >= 8) begin
                reportFailure("timed out waiting for pending read responses");
            end
            @(posedge Clk);
            guard++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Response compare, one cycle after each read strobe
    // ------------------------------------------------------------------------
    always @(posedge Clk) begin
        strobeSeen = dMemRdEnQ103H && rstN;
        if (strobeSeen) begin
            @(negedge Clk);
            if (expQ.size() == 0) begin
                reportFailure("read response arrived with no expected value queued");
            end
            expWord = expQ.pop_front();
            nameNow = nameQ.pop_front();
            assert (dMemRdRspQ104H === expWord) else begin
                reportFailure($sformatf("error %s expected %h actual %h",
                                        nameNow, expWord, dMemRdRspQ104H));
            end
            checkCount++;
        end
    end

    initial begin
        tAddr a;
        tWord r;
        Clk = 1'b0;
        rstN = 1'b0;
        pcQ100H = '0;
        dMemWrDataQ103H = '0;
        dMemAddressQ103H = '0;
        dMemByteEnQ103H = '0;
        dMemWrEnQ103H = 1'b0;
        dMemRdEnQ103H = 1'b0;
        button0 = 1'b0;
        button1 = 1'b0;
        switch = '0;
        rngState = 32'd74;
        ledS = '0;
        segS = '0;
        scratchS = '0;
        checkCount = 0;
        testName = "reset";
        $readmemh("test/instrMem.hex", imgShadow);

        waitCycles(5);
        rstN <= 1'b1;
        checkOutputs();

        // Fetch through the whole image
        testName = "fetch";
        for (int i = 0; i < 16; i++) begin
            @(posedge Clk);
            pcQ100H <= tAddr'(4 * i);
            waitCycles(1);
            @(negedge Clk);
            assert (instructionQ101H === imgShadow[i]) else begin
                reportFailure($sformatf("error %s expected %h actual %h",
                                        testName, imgShadow[i], instructionQ101H));
            end
        end

        // Every data word written once
        testName = "fill";
        for (int w = 0; w < 1024; w++) begin
            a = DMEM_BASE + 4 * w;
            access(1'b1, a, a ^ {a[15:0], a[31:16]}, 4'hF);
        end

        testName = "aligned";
        repeat (40) begin
            a = DMEM_BASE | (nextRand() & 32'h0000_0FFC);
            access(1'b1, a, nextRand(), 4'hF);
            access(1'b0, a, '0, '0);
            access(1'b0, DMEM_BASE | (nextRand() & 32'h0000_0FFC), '0, '0);
        end

        // Byte and half-word stores at any offset
        testName = "subword";
        repeat (60) begin
            a = DMEM_BASE | (nextRand() & 32'h0000_0FFF);
            r = nextRand();
            access(1'b1, a, nextRand(), tByteEn'(r));
            access(1'b0, (a & ~32'h3) | ((r >> 8) & 32'h3), '0, '0);
            access(1'b0, a, '0, '0);
        end

        testName = "ctrl";
        access(1'b1, CR_BASE, nextRand(), 4'hF);
        idleBus();
        checkOutputs();
        access(1'b1, CR_BASE + 4, nextRand(), 4'hF);
        access(1'b1, CR_BASE + 16, nextRand(), 4'hF);
        idleBus();
        checkOutputs();
        access(1'b0, CR_BASE, '0, '0);
        access(1'b0, CR_BASE + 4, '0, '0);
        access(1'b0, CR_BASE + 16, '0, '0);

        // Inputs cross the two flop synchronizer first
        testName = "board";
        repeat (8) begin
            idleBus();
            r = nextRand();
            switch <= r[9:0];
            button0 <= r[10];
            button1 <= r[11];
            waitCycles(2);
            access(1'b0, CR_BASE + 12, '0, '0);
            access(1'b0, CR_BASE + 8, '0, '0);
        end

        testName = "unmapped";
        access(1'b0, 32'h0000_0040, '0, '0);
        access(1'b0, 32'h0003_0000, '0, '0);
        access(1'b0, 32'hFFFF_F008, '0, '0);
        access(1'b0, CR_BASE + 32'h14, '0, '0);
        access(1'b0, CR_BASE + 32'hFC, '0, '0);
        // Would alias data words 0x40 and 0x10 if decoded wrongly
        access(1'b1, 32'h0003_0040, nextRand(), 4'hF);
        access(1'b1, 32'h0000_0010, nextRand(), 4'hF);
        access(1'b1, CR_BASE + 32'h14, nextRand(), 4'hF);
        idleBus();
        checkOutputs();
        access(1'b0, DMEM_BASE + 32'h40, '0, '0);
        access(1'b0, DMEM_BASE + 32'h10, '0, '0);
        access(1'b0, CR_BASE, '0, '0);
        access(1'b0, CR_BASE + 4, '0, '0);
        access(1'b0, CR_BASE + 16, '0, '0);
        idleBus();

        drainChecks();
        if (checkCount == 0) begin
            reportFailure("no read responses were checked");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: test/instrMem.hex
// One 32-bit instruction word per line, word address 0 upward
00000093
00100113
00010237
000202b7
00222023
00022183
002080b3
0012a023
00410113
0042a223
0002a303
00130313
0062a823
fe0008e3
00000013
0000006f

// File: sim.f
hdl/coreMemTypesPkg.sv
hdl/coreMemMapPkg.sv
hdl/memPortIf.sv
hdl/instrMem.sv
hdl/dataMem.sv
hdl/ctrlRegFile.sv
hdl/coreMemWrap.sv
test/coreMemWrap_sva.sv
test/coreMemWrapTb.sv

// File: Bender.yml
package:
  name: core_mem_wrap

sources:
  - hdl/coreMemTypesPkg.sv
  - hdl/coreMemMapPkg.sv
  - hdl/memPortIf.sv
  - hdl/instrMem.sv
  - hdl/dataMem.sv
  - hdl/ctrlRegFile.sv
  - hdl/coreMemWrap.sv
  - target: test
    files:
      - test/coreMemWrap_sva.sv
      - test/coreMemWrapTb.sv
